// File: cpu.sv
// single-issue core without loads, stores or CSRs; bus size and error response are not used
module cpu import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     if_ready_i,
  input  xlen_t    if_data_read_i,
  output logic     if_valid_o,
  output xlen_t    if_addr_o,
  output logic     cmt_valid_o,
  output xlen_t    cmt_pc_o,
  output inst_t    cmt_inst_o,
  output reg_idx_t cmt_rd_o,
  output logic     cmt_rd_wen_o,
  output xlen_t    cmt_rd_wdata_o
);

  // stage handshakes
  logic     fetched_req;
  logic     fetched_ack;
  logic     decoded_req;
  logic     decoded_ack;
  logic     executed_req;
  logic     executed_ack;

  // if -> id
  xlen_t    if_pc;
  inst_t    if_inst;
  // id <-> regfile
  reg_idx_t id_rs1;
  reg_idx_t id_rs2;
  xlen_t    rf_rs1_data;
  xlen_t    rf_rs2_data;
  // id -> exe
  alu_op_t  id_alu_op;
  xlen_t    id_op1;
  xlen_t    id_op2;
  xlen_t    id_br_a;
  xlen_t    id_br_b;
  br_kind_t id_br_kind;
  xlen_t    id_target;
  reg_idx_t id_rd;
  logic     id_rd_wen;
  xlen_t    id_pc;
  inst_t    id_inst;
  // exe -> wb, exe -> if
  reg_idx_t ex_rd;
  logic     ex_rd_wen;
  xlen_t    ex_rd_wdata;
  logic     ex_jump;
  xlen_t    ex_jump_addr;
  xlen_t    ex_pc;
  inst_t    ex_inst;
  // wb -> regfile, wb -> if
  logic     wb_reg_wen;
  logic     wb_commit;

  if_stage if_stage_inst (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .if_ready_i     (if_ready_i),
    .if_data_read_i (if_data_read_i),
    .fetched_ack_i  (fetched_ack),
    .commit_i       (wb_commit),
    .jump_i         (ex_jump),
    .jump_addr_i    (ex_jump_addr),
    .if_valid_o     (if_valid_o),
    .if_addr_o      (if_addr_o),
    .fetched_req_o  (fetched_req),
    .pc_o           (if_pc),
    .inst_o         (if_inst)
  );

  id_stage id_stage_inst (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .fetched_req_i  (fetched_req),
    .inst_i         (if_inst),
    .pc_i           (if_pc),
    .rs1_data_i     (rf_rs1_data),
    .rs2_data_i     (rf_rs2_data),
    .decoded_ack_i  (decoded_ack),
    .fetched_ack_o  (fetched_ack),
    .rs1_o          (id_rs1),
    .rs2_o          (id_rs2),
    .decoded_req_o  (decoded_req),
    .alu_op_o       (id_alu_op),
    .op1_o          (id_op1),
    .op2_o          (id_op2),
    .br_a_o         (id_br_a),
    .br_b_o         (id_br_b),
    .br_kind_o      (id_br_kind),
    .target_o       (id_target),
    .rd_o           (id_rd),
    .rd_wen_o       (id_rd_wen),
    .pc_o           (id_pc),
    .inst_o         (id_inst)
  );

  regfile regfile_inst (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .rs1_i          (id_rs1),
    .rs2_i          (id_rs2),
    .rd_i           (cmt_rd_o),
    .rd_wen_i       (wb_reg_wen),
    .rd_data_i      (cmt_rd_wdata_o),
    .rs1_data_o     (rf_rs1_data),
    .rs2_data_o     (rf_rs2_data)
  );

  exe_stage exe_stage_inst (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .decoded_req_i  (decoded_req),
    .alu_op_i       (id_alu_op),
    .op1_i          (id_op1),
    .op2_i          (id_op2),
    .br_a_i         (id_br_a),
    .br_b_i         (id_br_b),
    .br_kind_i      (id_br_kind),
    .target_i       (id_target),
    .rd_i           (id_rd),
    .rd_wen_i       (id_rd_wen),
    .pc_i           (id_pc),
    .inst_i         (id_inst),
    .executed_ack_i (executed_ack),
    .decoded_ack_o  (decoded_ack),
    .executed_req_o (executed_req),
    .rd_o           (ex_rd),
    .rd_wen_o       (ex_rd_wen),
    .rd_wdata_o     (ex_rd_wdata),
    .jump_o         (ex_jump),
    .jump_addr_o    (ex_jump_addr),
    .pc_o           (ex_pc),
    .inst_o         (ex_inst)
  );

  wb_stage wb_stage_inst (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .executed_req_i (executed_req),
    .rd_i           (ex_rd),
    .rd_wen_i       (ex_rd_wen),
    .rd_wdata_i     (ex_rd_wdata),
    .pc_i           (ex_pc),
    .inst_i         (ex_inst),
    .executed_ack_o (executed_ack),
    .reg_wen_o      (wb_reg_wen),
    .commit_o       (wb_commit),
    .cmt_valid_o    (cmt_valid_o),
    .cmt_pc_o       (cmt_pc_o),
    .cmt_inst_o     (cmt_inst_o),
    .cmt_rd_o       (cmt_rd_o),
    .cmt_rd_wen_o   (cmt_rd_wen_o),
    .cmt_rd_wdata_o (cmt_rd_wdata_o)
  );

endmodule

// File: cpu_asserts.sv
// checks bus hold, commit latency and fetch/commit exclusion; inactive during reset
module cpu_asserts import rv_pkg::*; (
  input logic  clk,
  input logic  arst_n_i,
  input logic  if_valid_i,
  input logic  if_ready_i,
  input xlen_t if_addr_i,
  input logic  cmt_valid_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // number of property failures so far
  int fail_cnt = 0;

  // request holds until ready
  req_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    if_valid_i && !if_ready_i |=> if_valid_i && $stable(if_addr_i))
    else begin
      $error("fetch request dropped or address changed before ready");
      fail_cnt++;
    end

  // strobe rises at the third edge after acceptance
  cmt_latency_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    if_valid_i && if_ready_i |=> !cmt_valid_i ##1 !cmt_valid_i ##1 !cmt_valid_i
                                 ##1 cmt_valid_i)
    else begin
      $error("commit strobe not 3 cycles after accepted fetch");
      fail_cnt++;
    end

  no_overlap_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    !(cmt_valid_i && if_valid_i))
    else begin
      $error("commit strobe and fetch request high together");
      fail_cnt++;
    end

endmodule

bind cpu cpu_asserts cpu_asserts_inst (
  .clk         (clk),
  .arst_n_i    (arst_n_i),
  .if_valid_i  (if_valid_o),
  .if_ready_i  (if_ready_i),
  .if_addr_i   (if_addr_o),
  .cmt_valid_i (cmt_valid_o)
);

// File: cpu_tb.sv
// random program fixed by the LFSR seed; uses x0..x7 only and stops after 300 commits
`include "rv_consts.svh"

module cpu_tb import rv_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DELAY  = 2;
  localparam int NUM_COMMITS  = 300;
  localparam int PROG_WORDS   = 64;
  localparam int WATCHDOG_NS  = NUM_COMMITS * (3 + 4 + 2) * CLK_PERIOD
                                + RESET_CYCLES * CLK_PERIOD;
  localparam logic [6:0] ILLEGAL_OP = 7'b0001011;

  logic     clk = 1'b0;
  logic     arst_n_i;
  logic     if_ready_i;
  xlen_t    if_data_read_i;
  logic     if_valid_o;
  xlen_t    if_addr_o;
  logic     cmt_valid_o;
  xlen_t    cmt_pc_o;
  inst_t    cmt_inst_o;
  reg_idx_t cmt_rd_o;
  logic     cmt_rd_wen_o;
  xlen_t    cmt_rd_wdata_o;

  logic [31:0] lfsr;
  inst_t       prog [PROG_WORDS];
  xlen_t       ref_regs [32];
  int          commits;
  int          xlen_errs;
  int          inst_errs;
  int          idx_errs;
  int          bit_errs;

  cpu cpu_inst (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .if_ready_i     (if_ready_i),
    .if_data_read_i (if_data_read_i),
    .if_valid_o     (if_valid_o),
    .if_addr_o      (if_addr_o),
    .cmt_valid_o    (cmt_valid_o),
    .cmt_pc_o       (cmt_pc_o),
    .cmt_inst_o     (cmt_inst_o),
    .cmt_rd_o       (cmt_rd_o),
    .cmt_rd_wen_o   (cmt_rd_wen_o),
    .cmt_rd_wdata_o (cmt_rd_wdata_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd);
    return {imm, rs1, f3, rd, `OP_IMM};
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, `OP_REG};
  endfunction

  function automatic inst_t enc_j(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
  endfunction

  function automatic inst_t enc_b(input logic [20:0] off, input reg_idx_t rs1,
                                  input reg_idx_t rs2, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
  endfunction

  // jump and branch targets stay inside the 64 words
  task automatic gen_program();
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [11:0] imm;
    logic [20:0] off;
    int          tgt;
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      rd  = 5'(rand_bits(3));
      rs1 = 5'(rand_bits(3));
      rs2 = 5'(rand_bits(3));
      imm = 12'(rand_bits(12));
      tgt = int'(rand_bits(6));
      if (tgt == i) begin
        tgt = i + 1;
      end
      off = 21'((tgt - i) * 4);
      case (rand_bits(4))
        0, 1:    prog[i] = enc_i(imm, rs1, `F3_ADD, rd);
        2:       prog[i] = enc_i(imm, rs1, `F3_AND, rd);
        3:       prog[i] = enc_i(imm, rs1, `F3_OR, rd);
        4:       prog[i] = enc_i(imm, rs1, `F3_XOR, rd);
        5:       prog[i] = enc_i(imm, rs1, `F3_SLT, rd);
        6:       prog[i] = enc_r(`F7_BASE, rs2, rs1, `F3_ADD, rd);
        7:       prog[i] = enc_r(`F7_SUB, rs2, rs1, `F3_ADD, rd);
        8:       prog[i] = enc_r(`F7_BASE, rs2, rs1, `F3_AND, rd);
        9:       prog[i] = enc_r(`F7_BASE, rs2, rs1, `F3_OR, rd);
        10:      prog[i] = enc_r(`F7_BASE, rs2, rs1, `F3_XOR, rd);
        11:      prog[i] = enc_r(`F7_BASE, rs2, rs1, `F3_SLT, rd);
        12:      prog[i] = {20'(rand_bits(20)), rd, `OP_LUI};
        13:      prog[i] = enc_j(off, rd);
        14:      prog[i] = enc_b(off, rs1, rs2, rand_bits(1) != 0 ? `F3_BNE : `F3_BEQ);
        default: prog[i] = {25'(rand_bits(25)), ILLEGAL_OP};
      endcase
    end
    // park on the last word
    prog[PROG_WORDS - 1] = enc_j(21'd0, 5'd0);
  endtask

  function automatic xlen_t fetch_beat(input xlen_t addr);
    xlen_t off;
    off = addr - `RV_RESET_PC;
    if (off >= xlen_t'(PROG_WORDS * 4)) begin
      return ~addr ^ 64'h5a5a_5a5a_a5a5_a5a5;
    end
    return {prog[{off[7:3], 1'b1}], prog[{off[7:3], 1'b0}]};
  endfunction

  // applies one instruction of the subset to ref_regs
  function automatic void step_ref(input xlen_t pc, input inst_t inst, output xlen_t next_pc,
                                   output logic wen, output xlen_t wdata);
    opcode_t    op;
    funct3_t    f3;
    logic [6:0] f7;
    xlen_t      a;
    xlen_t      b;
    xlen_t      imm_j;
    xlen_t      imm_b;
    op    = inst[6:0];
    f3    = inst[14:12];
    f7    = inst[31:25];
    a     = ref_regs[inst[19:15]];
    b     = ref_regs[inst[24:20]];
    imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    next_pc = pc + 64'd4;
    wen     = 1'b0;
    wdata   = '0;
    if (op == `OP_IMM || op == `OP_REG) begin
      if (op == `OP_IMM) begin
        b = {{52{inst[31]}}, inst[31:20]};
      end
      wen = (op == `OP_IMM) || (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'b000);
      case (f3)
        3'b000:  wdata = (op == `OP_REG && f7 == 7'h20) ? a - b : a + b;
        3'b010:  wdata = {63'b0, $signed(a) < $signed(b)};
        3'b100:  wdata = a ^ b;
        3'b110:  wdata = a | b;
        3'b111:  wdata = a & b;
        default: wen = 1'b0;
      endcase
    end else if (op == `OP_LUI) begin
      wen   = 1'b1;
      wdata = {{32{inst[31]}}, inst[31:12], 12'b0};
    end else if (op == `OP_JAL) begin
      wen     = 1'b1;
      wdata   = pc + 64'd4;
      next_pc = pc + imm_j;
    end else if (op == `OP_BRANCH) begin
      if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
        next_pc = pc + imm_b;
      end
    end
    if (inst[11:7] == 5'd0) begin
      wen = 1'b0;
    end
    if (wen) begin
      ref_regs[inst[11:7]] = wdata;
    end
  endfunction

  task automatic check_xlen(input string what, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      xlen_errs++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_inst(input string what, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      inst_errs++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      idx_errs++;
      $display("[ERROR] %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  initial begin
    arst_n_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    arst_n_i = 1'b1;
  end

  // memory model answers after 0 to 3 wait cycles
  initial begin : bus_model
    int   wait_left;
    logic armed;
    if_ready_i     = 1'b0;
    if_data_read_i = '0;
    armed          = 1'b0;
    wait_left      = 0;
    lfsr           = 32'h50387b65;
    gen_program();
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (if_valid_o === 1'b1) begin
        if (!armed) begin
          wait_left = int'(rand_bits(2));
          armed     = 1'b1;
        end
        if (wait_left == 0) begin
          if_ready_i     = 1'b1;
          if_data_read_i = fetch_beat(if_addr_o);
          armed          = 1'b0;
        end else begin
          if_ready_i     = 1'b0;
          if_data_read_i = '0;
          wait_left--;
        end
      end else begin
        if_ready_i     = 1'b0;
        if_data_read_i = '0;
      end
    end
  end

  initial begin : compare
    xlen_t exp_pc;
    xlen_t exp_next;
    xlen_t exp_wdata;
    xlen_t off;
    inst_t exp_inst;
    logic  exp_wen;
    commits   = 0;
    xlen_errs = 0;
    inst_errs = 0;
    idx_errs  = 0;
    bit_errs  = 0;
    exp_pc    = `RV_RESET_PC;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    while (commits < NUM_COMMITS) begin
      @(negedge clk);
      if (cmt_valid_o === 1'b1) begin
        off      = exp_pc - `RV_RESET_PC;
        exp_inst = prog[off[7:2]];
        step_ref(exp_pc, exp_inst, exp_next, exp_wen, exp_wdata);
        check_xlen("commit pc", cmt_pc_o, exp_pc);
        check_inst("commit inst", cmt_inst_o, exp_inst);
        check_reg_idx("commit rd", cmt_rd_o, exp_inst[11:7]);
        check_bit("commit rd_wen", cmt_rd_wen_o, exp_wen);
        if (exp_wen) begin
          check_xlen("commit rd_wdata", cmt_rd_wdata_o, exp_wdata);
        end
        exp_pc = exp_next;
        commits++;
      end
    end
    $display("commits %0d, errors: xlen %0d, inst %0d, reg index %0d, bit %0d, assert %0d",
             commits, xlen_errs, inst_errs, idx_errs, bit_errs,
             cpu_inst.cpu_asserts_inst.fail_cnt);
    if (xlen_errs + inst_errs + idx_errs + bit_errs
        + cpu_inst.cpu_asserts_inst.fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    #WATCHDOG_NS;
    $display("timeout: only %0d of %0d commits seen before the time limit",
             commits, NUM_COMMITS);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: exe_stage.sv
// 64-bit alu with signed slt only; jump_o is held while executed_req_o is high
`include "rv_consts.svh"

module exe_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     decoded_req_i,
  input  alu_op_t  alu_op_i,
  input  xlen_t    op1_i,
  input  xlen_t    op2_i,
  input  xlen_t    br_a_i,
  input  xlen_t    br_b_i,
  input  br_kind_t br_kind_i,
  input  xlen_t    target_i,
  input  reg_idx_t rd_i,
  input  logic     rd_wen_i,
  input  xlen_t    pc_i,
  input  inst_t    inst_i,
  input  logic     executed_ack_i,
  output logic     decoded_ack_o,
  output logic     executed_req_o,
  output reg_idx_t rd_o,
  output logic     rd_wen_o,
  output xlen_t    rd_wdata_o,
  output logic     jump_o,
  output xlen_t    jump_addr_o,
  output xlen_t    pc_o,
  output inst_t    inst_o
);

  xlen_t alu_res;
  logic  take;
  logic  fire;
  logic  executed_req_q;
  logic  jump_q;

  always_comb begin
    case (alu_op_i)
      `ALU_ADD:  alu_res = op1_i + op2_i;
      `ALU_SUB:  alu_res = op1_i - op2_i;
      `ALU_AND:  alu_res = op1_i & op2_i;
      `ALU_OR:   alu_res = op1_i | op2_i;
      `ALU_XOR:  alu_res = op1_i ^ op2_i;
      `ALU_SLT:  alu_res = {63'b0, $signed(op1_i) < $signed(op2_i)};
      `ALU_PASS: alu_res = op2_i;
      default:   alu_res = '0;
    endcase
  end

  always_comb begin
    case (br_kind_i)
      `BR_BEQ: take = (br_a_i == br_b_i);
      `BR_BNE: take = (br_a_i != br_b_i);
      `BR_JAL: take = 1'b1;
      default: take = 1'b0;
    endcase
  end

  assign decoded_ack_o  = decoded_req_i & ~executed_req_q;
  assign fire           = decoded_req_i & decoded_ack_o;
  assign executed_req_o = executed_req_q;
  assign jump_o         = jump_q;

  // jump decision drops together with the request
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      executed_req_q <= 1'b0;
      jump_q         <= 1'b0;
    end else if (fire) begin
      executed_req_q <= 1'b1;
      jump_q         <= take;
    end else if (executed_ack_i) begin
      executed_req_q <= 1'b0;
      jump_q         <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      rd_o        <= rd_i;
      rd_wen_o    <= rd_wen_i;
      rd_wdata_o  <= alu_res;
      jump_addr_o <= target_i;
      pc_o        <= pc_i;
      inst_o      <= inst_i;
    end
  end

endmodule

// File: filelist.f
+incdir+.
rv_pkg.sv
regfile.sv
if_stage.sv
id_stage.sv
exe_stage.sv
wb_stage.sv
cpu.sv
cpu_asserts.sv
cpu_tb.sv

// File: id_stage.sv
// decodes the supported subset only; anything else becomes a no-op with no register write
`include "rv_consts.svh"

module id_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     fetched_req_i,
  input  inst_t    inst_i,
  input  xlen_t    pc_i,
  input  xlen_t    rs1_data_i,
  input  xlen_t    rs2_data_i,
  input  logic     decoded_ack_i,
  output logic     fetched_ack_o,
  output reg_idx_t rs1_o,
  output reg_idx_t rs2_o,
  output logic     decoded_req_o,
  output alu_op_t  alu_op_o,
  output xlen_t    op1_o,
  output xlen_t    op2_o,
  output xlen_t    br_a_o,
  output xlen_t    br_b_o,
  output br_kind_t br_kind_o,
  output xlen_t    target_o,
  output reg_idx_t rd_o,
  output logic     rd_wen_o,
  output xlen_t    pc_o,
  output inst_t    inst_o
);

  opcode_t  opcode;
  funct3_t  funct3;
  logic [6:0] funct7;
  xlen_t    imm_i;
  xlen_t    imm_u;
  xlen_t    imm_j;
  xlen_t    imm_b;
  alu_op_t  d_alu_op;
  xlen_t    d_op2;
  br_kind_t d_br_kind;
  xlen_t    d_target;
  logic     d_rd_wen;
  logic     fire;
  logic     decoded_req_q;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];

  // sign-extended immediates
  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  always_comb begin
    d_alu_op  = `ALU_ADD;
    d_op2     = imm_i;
    d_br_kind = `BR_NONE;
    d_target  = pc_i + imm_b;
    d_rd_wen  = 1'b0;
    case (opcode)
      `OP_IMM: begin
        d_rd_wen = 1'b1;
        case (funct3)
          `F3_ADD: d_alu_op = `ALU_ADD;
          `F3_SLT: d_alu_op = `ALU_SLT;
          `F3_XOR: d_alu_op = `ALU_XOR;
          `F3_OR:  d_alu_op = `ALU_OR;
          `F3_AND: d_alu_op = `ALU_AND;
          default: d_rd_wen = 1'b0;
        endcase
      end
      `OP_REG: begin
        d_op2    = rs2_data_i;
        d_rd_wen = (funct7 == `F7_BASE) || (funct7 == `F7_SUB && funct3 == `F3_ADD);
        case (funct3)
          `F3_ADD: d_alu_op = (funct7 == `F7_SUB) ? `ALU_SUB : `ALU_ADD;
          `F3_SLT: d_alu_op = `ALU_SLT;
          `F3_XOR: d_alu_op = `ALU_XOR;
          `F3_OR:  d_alu_op = `ALU_OR;
          `F3_AND: d_alu_op = `ALU_AND;
          default: d_rd_wen = 1'b0;
        endcase
      end
      `OP_LUI: begin
        d_alu_op = `ALU_PASS;
        d_op2    = imm_u;
        d_rd_wen = 1'b1;
      end
      `OP_JAL: begin
        // link value rides through the alu
        d_alu_op  = `ALU_PASS;
        d_op2     = pc_i + 64'd4;
        d_br_kind = `BR_JAL;
        d_target  = pc_i + imm_j;
        d_rd_wen  = 1'b1;
      end
      `OP_BRANCH: begin
        if (funct3 == `F3_BEQ) begin
          d_br_kind = `BR_BEQ;
        end else if (funct3 == `F3_BNE) begin
          d_br_kind = `BR_BNE;
        end
      end
      default: d_rd_wen = 1'b0;
    endcase
  end

  assign fetched_ack_o = fetched_req_i & ~decoded_req_q;
  assign fire          = fetched_req_i & fetched_ack_o;
  assign decoded_req_o = decoded_req_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      decoded_req_q <= 1'b0;
    end else if (fire) begin
      decoded_req_q <= 1'b1;
    end else if (decoded_ack_i) begin
      decoded_req_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      alu_op_o  <= d_alu_op;
      op1_o     <= rs1_data_i;
      op2_o     <= d_op2;
      br_a_o    <= rs1_data_i;
      br_b_o    <= rs2_data_i;
      br_kind_o <= d_br_kind;
      target_o  <= d_target;
      rd_o      <= inst_i[11:7];
      rd_wen_o  <= d_rd_wen;
      pc_o      <= pc_i;
      inst_o    <= inst_i;
    end
  end

endmodule

// File: if_stage.sv
// fetches one instruction at a time and waits for its commit; 4-byte aligned PC assumed
`include "rv_consts.svh"

module if_stage import rv_pkg::*; (
  input  logic   clk,
  input  logic   arst_n_i,
  input  logic   if_ready_i,
  input  xlen_t  if_data_read_i,
  input  logic   fetched_ack_i,
  input  logic   commit_i,
  input  logic   jump_i,
  input  xlen_t  jump_addr_i,
  output logic   if_valid_o,
  output xlen_t  if_addr_o,
  output logic   fetched_req_o,
  output xlen_t  pc_o,
  output inst_t  inst_o
);

  fetch_state_e state_q;
  xlen_t        pc_q;
  xlen_t        jmp_addr_q;
  logic         jmp_pend_q;
  logic         fetched_req_q;
  inst_t        inst_q;
  logic         accept;

  assign if_valid_o    = (state_q == FETCH_REQ);
  assign if_addr_o     = pc_q;
  assign accept        = if_valid_o & if_ready_i;
  assign fetched_req_o = fetched_req_q;
  assign pc_o          = pc_q;
  assign inst_o        = inst_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= FETCH_IDLE;
      pc_q          <= `RV_RESET_PC;
      jmp_pend_q    <= 1'b0;
      fetched_req_q <= 1'b0;
    end else begin
      case (state_q)
        FETCH_IDLE: state_q <= FETCH_REQ;
        FETCH_REQ: begin
          if (accept) begin
            state_q       <= FETCH_WAIT;
            fetched_req_q <= 1'b1;
          end
        end
        FETCH_WAIT: begin
          if (commit_i) begin
            state_q    <= FETCH_REQ;
            pc_q       <= jmp_pend_q ? jmp_addr_q : pc_q + 64'd4;
            jmp_pend_q <= 1'b0;
          end
        end
        default: state_q <= FETCH_IDLE;
      endcase
      if (fetched_req_q && fetched_ack_i) begin
        fetched_req_q <= 1'b0;
      end
      // redirect arrives a cycle before the commit pulse
      if (jump_i) begin
        jmp_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    // pick the half of the beat that holds the word
    if (accept) begin
      inst_q <= pc_q[2] ? if_data_read_i[63:32] : if_data_read_i[31:0];
    end
    if (jump_i) begin
      jmp_addr_q <= jump_addr_i;
    end
  end

endmodule

// File: regfile.sv
// 32 x 64-bit registers with combinational reads; x0 reads zero and ignores writes
module regfile import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n_i,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  input  reg_idx_t rd_i,
  input  logic     rd_wen_i,
  input  xlen_t    rd_data_i,
  output xlen_t    rs1_data_o,
  output xlen_t    rs2_data_o
);

  xlen_t regs [32];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_wen_i && (rd_i != 5'd0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // regs[0] stays at its reset value
  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

endmodule

// File: run.sh
#!/bin/sh
# build and run cpu_tb with Verilator, exit status follows the testbench result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module cpu_tb -f filelist.f -o cpu_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/cpu_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: rv_consts.svh
// reset PC is fixed at 0x8000_0000; only the RV64I subset decoded by id_stage is encoded here
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_RESET_PC   64'h0000_0000_8000_0000

// major opcodes
`define OP_IMM        7'b0010011
`define OP_REG        7'b0110011
`define OP_LUI        7'b0110111
`define OP_JAL        7'b1101111
`define OP_BRANCH     7'b1100011

// funct3 / funct7 codes
`define F3_ADD        3'b000
`define F3_SLT        3'b010
`define F3_XOR        3'b100
`define F3_OR         3'b110
`define F3_AND        3'b111
`define F3_BEQ        3'b000
`define F3_BNE        3'b001
`define F7_BASE       7'b0000000
`define F7_SUB        7'b0100000

// alu operations
`define ALU_ADD       4'd0
`define ALU_SUB       4'd1
`define ALU_AND       4'd2
`define ALU_OR        4'd3
`define ALU_XOR       4'd4
`define ALU_SLT       4'd5
`define ALU_PASS      4'd6

// branch kinds
`define BR_NONE       2'd0
`define BR_BEQ        2'd1
`define BR_BNE        2'd2
`define BR_JAL        2'd3

`endif

// File: rv_pkg.sv
// types for a 64-bit core with 32-bit instructions; no compressed or wider encodings
package rv_pkg;

  // data word and program counter
  typedef logic [63:0] xlen_t;

  // raw instruction word
  typedef logic [31:0] inst_t;

  // architectural register index
  typedef logic [4:0] reg_idx_t;

  // alu operation select, see ALU_* codes
  typedef logic [3:0] alu_op_t;

  // instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // none, beq, bne or jal, see BR_* codes
  typedef logic [1:0] br_kind_t;

  // fetch sequencing, one instruction in flight
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT
  } fetch_state_e;

endpackage

// File: wb_stage.sv
// commit strobe lasts one cycle with no back-pressure; cmt_rd_wen_o is low for writes to x0
module wb_stage import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     executed_req_i,
  input  reg_idx_t rd_i,
  input  logic     rd_wen_i,
  input  xlen_t    rd_wdata_i,
  input  xlen_t    pc_i,
  input  inst_t    inst_i,
  output logic     executed_ack_o,
  output logic     reg_wen_o,
  output logic     commit_o,
  output logic     cmt_valid_o,
  output xlen_t    cmt_pc_o,
  output inst_t    cmt_inst_o,
  output reg_idx_t cmt_rd_o,
  output logic     cmt_rd_wen_o,
  output xlen_t    cmt_rd_wdata_o
);

  logic cmt_valid_q;

  assign executed_ack_o = executed_req_i & ~cmt_valid_q;
  assign cmt_valid_o    = cmt_valid_q;
  // regfile write and fetch release share the strobe cycle
  assign commit_o       = cmt_valid_q;
  assign reg_wen_o      = cmt_valid_q & cmt_rd_wen_o;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmt_valid_q <= 1'b0;
    end else begin
      cmt_valid_q <= executed_req_i & executed_ack_o;
    end
  end

  always_ff @(posedge clk) begin
    if (executed_req_i && executed_ack_o) begin
      cmt_pc_o       <= pc_i;
      cmt_inst_o     <= inst_i;
      cmt_rd_o       <= rd_i;
      cmt_rd_wen_o   <= rd_wen_i && (rd_i != 5'd0);
      cmt_rd_wdata_o <= rd_wdata_i;
    end
  end

endmodule
